// ==== filelist.f ====
logic/RiscvPkg.sv
logic/PipelinePkg.sv
logic/RegisterFile.sv
logic/StageIF.sv
logic/StageID.sv
logic/StageEX.sv
logic/StageMEM.sv
logic/Pipeline.sv
sim/PipelineTb.sv

// ==== logic/Pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module Pipeline (
    input  logic                         i_Clock,
    input  logic                         i_rstN,
    input  logic                         i_ImemWrEnable,  // Program load, reset only
    input  logic [RiscvPkg::IMEM_AW-1:0] i_ImemWrAddr,
    input  logic [RiscvPkg::XLEN-1:0]    i_ImemWrData,
    output logic                         o_WbValid,       // Register write retires
    output logic [4:0]                   o_WbRegAddr,
    output logic [RiscvPkg::XLEN-1:0]    o_WbData,
    output logic                         o_DmemWrEnable,
    output logic [RiscvPkg::XLEN-1:0]    o_DmemWrAddr,
    output logic [RiscvPkg::XLEN-1:0]    o_DmemWrData);

    import RiscvPkg::*;
    import PipelinePkg::*;

    IfIdReg          ifId;
    IdExReg          idEx;
    ExMemReg         exMem;
    MemWbReg         memWb;
    FwdBus           exFwd;
    FwdBus           memFwd;
    logic            exIsLoad;
    logic            stall;
    logic            redirect;
    logic [XLEN-1:0] targetPC;

    StageIF u_StageIF (
        .i_Clock        (i_Clock),
        .i_rstN         (i_rstN),
        .i_ImemWrEnable (i_ImemWrEnable),
        .i_ImemWrAddr   (i_ImemWrAddr),
        .i_ImemWrData   (i_ImemWrData),
        .i_Stall        (stall),
        .i_Redirect     (redirect),
        .i_TargetPC     (targetPC),
        .o_IfId         (ifId));

    StageID u_StageID (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_IfId     (ifId),
        .i_ExFwd    (exFwd),
        .i_ExIsLoad (exIsLoad),
        .i_MemFwd   (memFwd),
        .i_MemWb    (memWb),
        .o_IdEx     (idEx),
        .o_Stall    (stall),
        .o_Redirect (redirect),
        .o_TargetPC (targetPC));

    StageEX u_StageEX (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_IdEx     (idEx),
        .o_ExMem    (exMem),
        .o_ExFwd    (exFwd),
        .o_ExIsLoad (exIsLoad));

    StageMEM u_StageMEM (
        .i_Clock        (i_Clock),
        .i_rstN         (i_rstN),
        .i_ExMem        (exMem),
        .o_MemWb        (memWb),
        .o_MemFwd       (memFwd),
        .o_DmemWrEnable (o_DmemWrEnable),
        .o_DmemWrAddr   (o_DmemWrAddr),
        .o_DmemWrData   (o_DmemWrData));

    assign o_WbValid   = memWb.valid && memWb.regWrEnable;  // Branches and SW stay silent
    assign o_WbRegAddr = memWb.rd;
    assign o_WbData    = memWb.wrData;

endmodule

`default_nettype wire

// ==== logic/PipelinePkg.sv ====
`default_nettype none

package PipelinePkg;

    typedef struct packed {
        logic                      valid;
        logic [RiscvPkg::XLEN-1:0] pc;
        RiscvPkg::Inst             inst;
    } IfIdReg;

    typedef struct packed {
        logic                      valid;
        logic [RiscvPkg::XLEN-1:0] pc;
        logic [RiscvPkg::XLEN-1:0] immediate;
        logic [RiscvPkg::XLEN-1:0] dataA;        // Forwarded rs1
        logic [RiscvPkg::XLEN-1:0] dataB;        // Forwarded rs2, also store data
        logic [4:0]                rd;
        logic                      regWrEnable;  // Never set for x0
        logic                      memWrEnable;
        logic                      isLoad;
        logic                      wbSel;        // 1 writes PC+4
        logic                      operandASel;  // 1 takes PC
        logic                      operandBSel;  // 1 takes immediate
        RiscvPkg::AluOp            aluOp;
    } IdExReg;

    typedef struct packed {
        logic                      valid;
        logic [4:0]                rd;
        logic                      regWrEnable;
        logic                      memWrEnable;
        logic                      isLoad;
        logic [RiscvPkg::XLEN-1:0] aluResult;    // Also load and store address
        logic [RiscvPkg::XLEN-1:0] storeData;
    } ExMemReg;

    typedef struct packed {
        logic                      valid;
        logic [4:0]                rd;
        logic                      regWrEnable;
        logic [RiscvPkg::XLEN-1:0] wrData;
    } MemWbReg;

    // Result published back to decode, 38 bits
    typedef struct packed {
        logic [4:0]                rd;
        logic                      enable;
        logic [RiscvPkg::XLEN-1:0] data;
    } FwdBus;

endpackage

`default_nettype wire

// ==== logic/RegisterFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module RegisterFile (
    input  logic                      i_Clock,
    input  logic                      i_rstN,
    input  logic                      i_WrEnable,
    input  logic [4:0]                i_WrAddr,
    input  logic [RiscvPkg::XLEN-1:0] i_WrData,
    input  logic [4:0]                i_RdAddrA,
    input  logic [4:0]                i_RdAddrB,
    output logic [RiscvPkg::XLEN-1:0] o_RdDataA,
    output logic [RiscvPkg::XLEN-1:0] o_RdDataB);

    import RiscvPkg::*;

    logic [XLEN-1:0] regs [1:31];             // x0 has no storage

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (i_WrEnable && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Same-cycle write visible to the reader
    assign o_RdDataA = (i_RdAddrA == '0) ? '0 :
                       (i_WrEnable && i_WrAddr == i_RdAddrA) ? i_WrData : regs[i_RdAddrA];
    assign o_RdDataB = (i_RdAddrB == '0) ? '0 :
                       (i_WrEnable && i_WrAddr == i_RdAddrB) ? i_WrData : regs[i_RdAddrB];

endmodule

`default_nettype wire

// ==== logic/RiscvPkg.sv ====
`default_nettype none

package RiscvPkg;

    localparam int XLEN       = 32;                  // Integer register width
    localparam int IMEM_DEPTH = 64;                  // Instruction words
    localparam int DMEM_DEPTH = 64;                  // Data words
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);  // Imem word address bits
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);  // Dmem word address bits

    // ------------------------------------------------
    // Major opcodes and ALU operations
    // ------------------------------------------------

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,   // ADD SUB AND OR XOR SLT SLL SRL
        OP_IMM    = 7'b0010011,   // ADDI ANDI ORI XORI SLTI
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,   // LW only
        OP_STORE  = 7'b0100011,   // SW only
        OP_BRANCH = 7'b1100011,   // BEQ BNE BLT BGE
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } Opcode;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                  // Signed less-than
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB                 // B straight through, LUI
    } AluOp;

    // ------------------------------------------------
    // Instruction formats, MSB first
    // ------------------------------------------------

    typedef struct packed {
        logic [6:0] funct7;       // Bit 5 picks SUB
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } RType;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } IType;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } SType;

    typedef struct packed {
        logic       imm12;        // Sign
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } BType;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } UType;

    typedef struct packed {
        logic       imm20;        // Sign
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } JType;

    // Same word, field layout chosen by opcode
    typedef union packed {
        RType r;
        IType i;
        SType s;
        BType b;
        UType u;
        JType j;
    } Inst;

endpackage

`default_nettype wire

// ==== logic/StageEX.sv ====
`timescale 1ns/10ps
`default_nettype none

module StageEX (
    input  logic                 i_Clock,
    input  logic                 i_rstN,
    input  PipelinePkg::IdExReg  i_IdEx,
    output PipelinePkg::ExMemReg o_ExMem,
    output PipelinePkg::FwdBus   o_ExFwd,     // Back to decode
    output logic                 o_ExIsLoad); // Load-use check in decode

    import RiscvPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] result;

    assign opA = i_IdEx.operandASel ? i_IdEx.pc : i_IdEx.dataA;
    assign opB = i_IdEx.operandBSel ? i_IdEx.immediate : i_IdEx.dataB;

    always_comb begin
        case (i_IdEx.aluOp)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;
            ALU_AND: aluOut = opA & opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_XOR: aluOut = opA ^ opB;
            ALU_SLT: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLL: aluOut = opA << opB[4:0];
            ALU_SRL: aluOut = opA >> opB[4:0];
            default: aluOut = opB;            // PASSB for LUI
        endcase
    end

    assign result = i_IdEx.wbSel ? i_IdEx.pc + 32'd4 : aluOut;  // Jump link

    // Enables already carry valid from decode
    always_comb begin
        o_ExFwd.rd     = i_IdEx.rd;
        o_ExFwd.enable = i_IdEx.regWrEnable;
        o_ExFwd.data   = result;              // Load address, never used thanks to stall
    end

    assign o_ExIsLoad = i_IdEx.isLoad;

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_ExMem <= '0;
        end else begin
            o_ExMem.valid       <= i_IdEx.valid;
            o_ExMem.rd          <= i_IdEx.rd;
            o_ExMem.regWrEnable <= i_IdEx.regWrEnable;
            o_ExMem.memWrEnable <= i_IdEx.memWrEnable;
            o_ExMem.isLoad      <= i_IdEx.isLoad;
            o_ExMem.aluResult   <= result;
            o_ExMem.storeData   <= i_IdEx.dataB;
        end
    end

endmodule

`default_nettype wire

// ==== logic/StageID.sv ====
`timescale 1ns/10ps
`default_nettype none

module StageID (
    input  logic                      i_Clock,
    input  logic                      i_rstN,
    input  PipelinePkg::IfIdReg       i_IfId,      // From fetch
    input  PipelinePkg::FwdBus        i_ExFwd,     // EX result before its register
    input  logic                      i_ExIsLoad,  // Load sits in EX
    input  PipelinePkg::FwdBus        i_MemFwd,    // MEM write data
    input  PipelinePkg::MemWbReg      i_MemWb,     // WB and regfile write port
    output PipelinePkg::IdExReg       o_IdEx,
    output logic                      o_Stall,     // Hold fetch and bubble into EX
    output logic                      o_Redirect,  // Taken branch or jump
    output logic [RiscvPkg::XLEN-1:0] o_TargetPC);

    import RiscvPkg::*;
    import PipelinePkg::*;

    // ------------------------------------------------
    // Fields and immediate
    // ------------------------------------------------

    Inst             inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;

    assign inst   = i_IfId.inst;
    assign opcode = inst.r.opcode;            // Same place in every format
    assign funct3 = inst.r.funct3;
    assign rs1    = inst.r.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;

    always_comb begin
        case (opcode)
            OP_LUI:    imm = {inst.u.imm31_12, 12'b0};
            OP_JAL:    imm = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                              inst.j.imm10_1, 1'b0};
            OP_BRANCH: imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                              inst.b.imm4_1, 1'b0};
            OP_STORE:  imm = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
            default:   imm = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};  // I-type
        endcase
    end

    // ------------------------------------------------
    // Datapath control
    // ------------------------------------------------

    function automatic AluOp aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    AluOp aluOp;
    logic regWr;
    logic memWr;
    logic isLoad;
    logic wbSel;
    logic opASel;
    logic opBSel;
    logic isBranch;
    logic isJump;
    logic usesRs1;
    logic usesRs2;

    always_comb begin
        aluOp    = ALU_ADD;                   // Address math by default
        regWr    = 1'b0;
        memWr    = 1'b0;
        isLoad   = 1'b0;
        wbSel    = 1'b0;
        opASel   = 1'b0;
        opBSel   = 1'b1;                      // Immediate unless R-type
        isBranch = 1'b0;
        isJump   = 1'b0;
        usesRs1  = 1'b1;
        usesRs2  = 1'b0;
        case (opcode)
            OP_REG: begin
                regWr   = 1'b1;
                opBSel  = 1'b0;
                usesRs2 = 1'b1;
                aluOp   = aluFromFunct(funct3, inst.r.funct7[5]);
            end
            OP_IMM: begin
                regWr = 1'b1;
                aluOp = aluFromFunct(funct3, 1'b0);   // No SUBI
            end
            OP_LUI: begin
                regWr   = 1'b1;
                usesRs1 = 1'b0;
                aluOp   = ALU_PASSB;
            end
            OP_LOAD: begin
                regWr  = 1'b1;
                isLoad = 1'b1;
            end
            OP_STORE: begin
                memWr   = 1'b1;
                usesRs2 = 1'b1;               // Store data
            end
            OP_BRANCH: begin
                isBranch = 1'b1;
                usesRs2  = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                regWr   = 1'b1;
                wbSel   = 1'b1;               // Link value PC+4
                opASel  = 1'b1;
                isJump  = 1'b1;
                usesRs1 = (opcode == OP_JALR);
            end
            default: usesRs1 = 1'b0;          // Unknown opcode runs as NOP
        endcase
    end

    // ------------------------------------------------
    // Register read and forwarding
    // ------------------------------------------------

    // Youngest producer wins and x0 is never forwarded
    function automatic logic [XLEN-1:0] pickOperand(
        input logic [4:0]      rs,
        input logic [XLEN-1:0] regData,
        input FwdBus           ex,
        input FwdBus           mem,
        input FwdBus           wb);
        if (rs != '0 && ex.enable && ex.rd == rs)
            return ex.data;
        if (rs != '0 && mem.enable && mem.rd == rs)
            return mem.data;
        if (rs != '0 && wb.enable && wb.rd == rs)
            return wb.data;
        return regData;
    endfunction

    FwdBus           wbFwd;
    logic [XLEN-1:0] regDataA;
    logic [XLEN-1:0] regDataB;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;

    assign wbFwd.rd     = i_MemWb.rd;
    assign wbFwd.enable = i_MemWb.valid && i_MemWb.regWrEnable;
    assign wbFwd.data   = i_MemWb.wrData;

    RegisterFile u_RegisterFile (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_WrEnable (wbFwd.enable),
        .i_WrAddr   (i_MemWb.rd),
        .i_WrData   (i_MemWb.wrData),
        .i_RdAddrA  (rs1),
        .i_RdAddrB  (rs2),
        .o_RdDataA  (regDataA),
        .o_RdDataB  (regDataB));

    assign opA = pickOperand(rs1, regDataA, i_ExFwd, i_MemFwd, wbFwd);
    assign opB = pickOperand(rs2, regDataB, i_ExFwd, i_MemFwd, wbFwd);

    // Load data not ready until MEM so wait one cycle
    assign o_Stall = i_IfId.valid && i_ExIsLoad && i_ExFwd.enable &&
                     ((usesRs1 && i_ExFwd.rd == rs1) || (usesRs2 && i_ExFwd.rd == rs2));

    // ------------------------------------------------
    // Early branch resolution and next PC
    // ------------------------------------------------

    logic            taken;
    logic [XLEN-1:0] jalrSum;

    always_comb begin
        case (funct3)
            3'b000:  taken = (opA == opB);                    // BEQ
            3'b001:  taken = (opA != opB);                    // BNE
            3'b100:  taken = ($signed(opA) < $signed(opB));   // BLT
            3'b101:  taken = ($signed(opA) >= $signed(opB));  // BGE
            default: taken = 1'b0;
        endcase
    end

    assign jalrSum    = opA + imm;
    assign o_Redirect = i_IfId.valid && !o_Stall && (isJump || (isBranch && taken));
    assign o_TargetPC = (opcode == OP_JALR) ? {jalrSum[XLEN-1:1], 1'b0} : i_IfId.pc + imm;

    logic live;
    assign live = i_IfId.valid && !o_Stall;   // Stall sends a bubble

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_IdEx <= '0;
        end else begin
            o_IdEx.valid       <= live;
            o_IdEx.regWrEnable <= live && regWr && rd != '0;
            o_IdEx.memWrEnable <= live && memWr;
            o_IdEx.isLoad      <= live && isLoad;
            o_IdEx.pc          <= i_IfId.pc;
            o_IdEx.immediate   <= imm;
            o_IdEx.dataA       <= opA;
            o_IdEx.dataB       <= opB;
            o_IdEx.rd          <= rd;
            o_IdEx.wbSel       <= wbSel;
            o_IdEx.operandASel <= opASel;
            o_IdEx.operandBSel <= opBSel;
            o_IdEx.aluOp       <= aluOp;
        end
    end

endmodule

`default_nettype wire

// ==== logic/StageIF.sv ====
`timescale 1ns/10ps
`default_nettype none

module StageIF (
    input  logic                         i_Clock,
    input  logic                         i_rstN,
    input  logic                         i_ImemWrEnable,  // Program load strobe
    input  logic [RiscvPkg::IMEM_AW-1:0] i_ImemWrAddr,    // Word address
    input  logic [RiscvPkg::XLEN-1:0]    i_ImemWrData,
    input  logic                         i_Stall,         // Load-use hold
    input  logic                         i_Redirect,      // Taken branch or jump
    input  logic [RiscvPkg::XLEN-1:0]    i_TargetPC,
    output PipelinePkg::IfIdReg          o_IfId);

    import RiscvPkg::*;

    logic [XLEN-1:0] pc;                      // Next fetch address
    logic [XLEN-1:0] imem [IMEM_DEPTH];       // Instruction store

    // Filled while the core sits in reset
    always_ff @(posedge i_Clock) begin
        if (i_ImemWrEnable) begin
            imem[i_ImemWrAddr] <= i_ImemWrData;
        end
    end

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            pc     <= '0;                     // First fetch at 0
            o_IfId <= '0;
        end else if (!i_Stall) begin          // Stall holds PC and IfId
            if (i_Redirect) begin
                pc           <= i_TargetPC;
                o_IfId.valid <= 1'b0;         // Drop the wrong-path word
            end else begin
                pc           <= pc + 32'd4;
                o_IfId.valid <= 1'b1;
                o_IfId.pc    <= pc;
                o_IfId.inst  <= imem[pc[IMEM_AW+1:2]];
            end
        end
    end

    // Decode targets keep fetch word aligned
    assert property (@(posedge i_Clock) disable iff (!i_rstN) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/StageMEM.sv ====
`timescale 1ns/10ps
`default_nettype none

module StageMEM (
    input  logic                      i_Clock,
    input  logic                      i_rstN,
    input  PipelinePkg::ExMemReg      i_ExMem,
    output PipelinePkg::MemWbReg      o_MemWb,
    output PipelinePkg::FwdBus        o_MemFwd,        // Back to decode
    output logic                      o_DmemWrEnable,  // SW strobe, observed at top
    output logic [RiscvPkg::XLEN-1:0] o_DmemWrAddr,    // Byte address
    output logic [RiscvPkg::XLEN-1:0] o_DmemWrData);

    import RiscvPkg::*;

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordAddr;
    logic [XLEN-1:0]    wrData;

    assign wordAddr = i_ExMem.aluResult[DMEM_AW+1:2];  // Wraps past the array
    assign wrData   = i_ExMem.isLoad ? dmem[wordAddr] : i_ExMem.aluResult;

    always_ff @(posedge i_Clock) begin
        if (i_ExMem.memWrEnable) begin
            dmem[wordAddr] <= i_ExMem.storeData;
        end
    end

    assign o_DmemWrEnable = i_ExMem.memWrEnable;
    assign o_DmemWrAddr   = i_ExMem.aluResult;
    assign o_DmemWrData   = i_ExMem.storeData;

    always_comb begin
        o_MemFwd.rd     = i_ExMem.rd;
        o_MemFwd.enable = i_ExMem.regWrEnable;
        o_MemFwd.data   = wrData;             // Load data arrives here
    end

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_MemWb <= '0;
        end else begin
            o_MemWb.valid       <= i_ExMem.valid;
            o_MemWb.rd          <= i_ExMem.rd;
            o_MemWb.regWrEnable <= i_ExMem.regWrEnable;
            o_MemWb.wrData      <= wrData;
        end
    end

    // Decode never marks one instruction as both load and store
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        !(i_ExMem.memWrEnable && i_ExMem.isLoad));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module PipelineTb -Mdir obj_dir \
    || { echo "Build failed"; exit 1; }

./obj_dir/VPipelineTb | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/PipelineTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module PipelineTb;

    import RiscvPkg::*;

    logic                 clock;
    logic                 rstN;
    logic                 imemWrEnable;
    logic [IMEM_AW-1:0]   imemWrAddr;
    logic [XLEN-1:0]      imemWrData;
    logic                 wbValid;
    logic [4:0]           wbRegAddr;
    logic [XLEN-1:0]      wbData;
    logic                 dmemWrEnable;
    logic [XLEN-1:0]      dmemWrAddr;
    logic [XLEN-1:0]      dmemWrData;

    logic [31:0] prog [$];                    // Program words by word address
    string       nameQ [$];                   // Retirements in program order
    logic [4:0]  rdQ [$];
    logic [31:0] valQ [$];
    string       storeNameQ [$];              // Stores in program order
    logic [31:0] addrQ [$];
    logic [31:0] dataQ [$];

    Pipeline u_Pipeline (
        .i_Clock        (clock),
        .i_rstN         (rstN),
        .i_ImemWrEnable (imemWrEnable),
        .i_ImemWrAddr   (imemWrAddr),
        .i_ImemWrData   (imemWrData),
        .o_WbValid      (wbValid),
        .o_WbRegAddr    (wbRegAddr),
        .o_WbData       (wbData),
        .o_DmemWrEnable (dmemWrEnable),
        .o_DmemWrAddr   (dmemWrAddr),
        .o_DmemWrData   (dmemWrData));

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;            // 8 ns period
    end

    // --------------------------------------------------
    // Encoders per ISA format
    // --------------------------------------------------

    function automatic logic [31:0] regOp(input int rd, rs1, rs2, f3, f7);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] immOp(input int rd, rs1, imm, f3, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] storeOp(input int rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};   // SW
    endfunction

    function automatic logic [31:0] branchOp(input int rs1, rs2, imm, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] upperOp(input int rd, imm20);
        return {imm20[19:0], rd[4:0], OP_LUI};
    endfunction

    function automatic logic [31:0] jumpOp(input int rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expectRetire(input string name, input int rd, input logic [31:0] val);
        nameQ.push_back(name);
        rdQ.push_back(rd[4:0]);
        valQ.push_back(val);
    endtask

    task automatic expectStore(input string name, input logic [31:0] addr, data);
        storeNameQ.push_back(name);
        addrQ.push_back(addr);
        dataQ.push_back(data);
    endtask

    function automatic string mismatchLine(input string name, input logic [31:0] exp, act);
        return $sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act);
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // Checkers sampled mid-cycle
    // --------------------------------------------------

    always @(negedge clock) begin
        if (rstN && wbValid) begin
            if (rdQ.size() == 0) begin
                abortRun($sformatf("Unexpected retirement to x%0d", wbRegAddr));
            end else begin
                assert (wbRegAddr == rdQ[0])
                    else abortRun(mismatchLine({nameQ[0], " rd"}, 32'(rdQ[0]), 32'(wbRegAddr)));
                assert (wbData == valQ[0])
                    else abortRun(mismatchLine(nameQ[0], valQ[0], wbData));
                void'(nameQ.pop_front());
                void'(rdQ.pop_front());
                void'(valQ.pop_front());
            end
        end
        if (rstN && dmemWrEnable) begin
            if (addrQ.size() == 0) begin
                abortRun($sformatf("Unexpected store to address %h", dmemWrAddr));
            end else begin
                assert (dmemWrAddr == addrQ[0])
                    else abortRun(mismatchLine({storeNameQ[0], " addr"}, addrQ[0], dmemWrAddr));
                assert (dmemWrData == dataQ[0])
                    else abortRun(mismatchLine(storeNameQ[0], dataQ[0], dmemWrData));
                void'(storeNameQ.pop_front());
                void'(addrQ.pop_front());
                void'(dataQ.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // Program, expectations, run
    // --------------------------------------------------

    initial begin
        int          immA;
        int          immB;
        int          pc;
        int          k;
        int          cycles;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] link;
        rstN         = 1'b0;
        imemWrEnable = 1'b0;
        imemWrAddr   = '0;
        imemWrData   = '0;
        void'($urandom(32'h6724_cf01));
        immA = $urandom() & 32'hfff;          // Random 12-bit immediates
        immB = $urandom() & 32'hfff;
        a    = {{20{immA[11]}}, immA[11:0]};
        b    = {{20{immB[11]}}, immB[11:0]};

        emit(immOp(1, 0, immA, 0, OP_IMM));
        expectRetire("addi x1", 1, a);
        emit(immOp(2, 0, immB, 0, OP_IMM));
        expectRetire("addi x2", 2, b);
        emit(regOp(3, 1, 2, 0, 0));
        expectRetire("add ex/mem fwd", 3, a + b);
        emit(regOp(4, 1, 2, 0, 32));
        expectRetire("sub wb fwd", 4, a - b);
        emit(regOp(5, 3, 4, 7, 0));
        expectRetire("and", 5, (a + b) & (a - b));
        emit(regOp(6, 1, 2, 6, 0));
        expectRetire("or regfile", 6, a | b);
        emit(regOp(7, 6, 5, 4, 0));
        expectRetire("xor", 7, (a | b) ^ ((a + b) & (a - b)));
        emit(regOp(8, 1, 2, 2, 0));
        expectRetire("slt", 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        emit(immOp(9, 0, 5, 0, OP_IMM));
        expectRetire("addi shamt", 9, 32'd5);
        emit(regOp(10, 1, 9, 1, 0));
        expectRetire("sll", 10, a << 5);
        emit(regOp(11, 1, 9, 5, 0));
        expectRetire("srl", 11, a >> 5);      // Logical
        emit(immOp(12, 1, 'h0f0, 7, OP_IMM));
        expectRetire("andi", 12, a & 32'h0f0);
        emit(immOp(13, 2, 'hf00, 6, OP_IMM));
        expectRetire("ori", 13, b | 32'hffff_ff00);
        emit(immOp(14, 1, 'h555, 4, OP_IMM));
        expectRetire("xori", 14, a ^ 32'h555);
        emit(immOp(15, 2, immA, 2, OP_IMM));
        expectRetire("slti", 15, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        emit(upperOp(16, 'h12345));
        expectRetire("lui", 16, 32'h1234_5000);
        emit(immOp(16, 16, 'h678, 0, OP_IMM));
        expectRetire("addi after lui", 16, 32'h1234_5678);

        // Store, load, immediate use
        emit(immOp(17, 0, 'h40, 0, OP_IMM));
        expectRetire("base", 17, 32'h40);
        emit(storeOp(16, 17, 8));
        expectStore("sw", 32'h48, 32'h1234_5678);
        emit(immOp(18, 17, 8, 2, OP_LOAD));
        expectRetire("lw", 18, 32'h1234_5678);
        emit(regOp(19, 18, 16, 0, 0));
        expectRetire("load-use add", 19, 32'h2468_acf0);
        emit(storeOp(19, 17, 12));
        expectStore("sw after stall", 32'h4c, 32'h2468_acf0);

        // Branches on operands from the previous instruction
        emit(immOp(20, 0, 7, 0, OP_IMM));
        expectRetire("x20", 20, 32'd7);
        emit(branchOp(20, 20, 8, 0));        // BEQ taken
        emit(immOp(21, 0, 1, 0, OP_IMM));    // Skipped
        emit(immOp(21, 0, -3, 0, OP_IMM));
        expectRetire("after beq", 21, -32'sd3);
        emit(branchOp(21, 20, 8, 1));        // BNE taken
        emit(immOp(22, 0, 99, 0, OP_IMM));   // Skipped
        emit(immOp(22, 0, -3, 0, OP_IMM));
        expectRetire("after bne", 22, -32'sd3);
        emit(branchOp(22, 20, 8, 0));        // BEQ not taken
        emit(immOp(25, 22, 4, 0, OP_IMM));
        expectRetire("after beq not taken", 25, 32'd1);
        emit(branchOp(20, 22, 8, 4));        // Signed BLT not taken
        emit(immOp(23, 0, 1, 0, OP_IMM));
        expectRetire("fall through", 23, 32'd1);
        emit(branchOp(22, 23, 8, 4));        // BLT taken
        emit(immOp(24, 0, 55, 0, OP_IMM));   // Skipped
        emit(immOp(24, 0, 7, 0, OP_IMM));
        expectRetire("after blt", 24, 32'd7);
        emit(branchOp(24, 20, 8, 5));        // BGE taken on equal
        emit(immOp(25, 0, 66, 0, OP_IMM));   // Skipped
        emit(branchOp(21, 24, 8, 5));        // BGE not taken
        emit(immOp(25, 24, 1, 0, OP_IMM));
        expectRetire("after bge not taken", 25, 32'd8);
        emit(branchOp(24, 20, 8, 1));        // BNE not taken

        // Jumps
        pc   = prog.size() * 4;
        link = pc + 4;
        emit(jumpOp(26, 12));
        expectRetire("jal link", 26, link);
        emit(immOp(27, 0, 11, 0, OP_IMM));   // Skipped
        emit(immOp(27, 0, 12, 0, OP_IMM));   // Skipped
        pc = (prog.size() + 4) * 4 - 3;      // Odd base so bit 0 gets cleared
        emit(immOp(28, 0, pc, 0, OP_IMM));
        expectRetire("jalr base", 28, pc);
        pc = prog.size() * 4;
        emit(immOp(29, 28, 4, 0, OP_JALR));
        expectRetire("jalr link", 29, pc + 4);
        emit(immOp(30, 0, 1, 0, OP_IMM));    // Skipped
        emit(immOp(30, 0, 2, 0, OP_IMM));    // Skipped
        emit(jumpOp(0, 8));                  // Link to x0 retires nothing
        emit(immOp(31, 0, 3, 0, OP_IMM));    // Skipped
        emit(immOp(31, 26, 1, 0, OP_IMM));
        expectRetire("after jal x0", 31, link + 1);
        emit(jumpOp(0, 0));                  // Park in a self loop

        // Load one word per cycle while in reset
        for (k = 0; k < prog.size(); k++) begin
            @(posedge clock);
            #1;
            imemWrEnable = 1'b1;
            imemWrAddr   = k[IMEM_AW-1:0];
            imemWrData   = prog[k];
        end
        @(posedge clock);
        #1;
        imemWrEnable = 1'b0;
        repeat (4) @(posedge clock);         // Four reset cycles after the load
        #1;
        rstN = 1'b1;

        for (cycles = 0; cycles < 2000 && (rdQ.size() != 0 || addrQ.size() != 0); cycles++) begin
            @(posedge clock);
        end
        if (rdQ.size() != 0 || addrQ.size() != 0) begin
            abortRun("Timeout with expected retirements or stores still pending");
        end else begin
            repeat (10) @(posedge clock);    // Catch stray retirements from the loop
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
